// File: design/mips_pkg.sv
package mips_pkg;

    // **********************************************************************
    // width types
    // **********************************************************************
    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  op_t;
    typedef logic [5:0]  func_t;

    // **********************************************************************
    // opcodes, function codes and regimm rt codes
    // **********************************************************************
    localparam op_t OP_SPECIAL = 6'b000000;
    localparam op_t OP_REGIMM  = 6'b000001;
    localparam op_t OP_J       = 6'b000010;
    localparam op_t OP_JAL     = 6'b000011;
    localparam op_t OP_BEQ     = 6'b000100;
    localparam op_t OP_BNE     = 6'b000101;
    localparam op_t OP_BLEZ    = 6'b000110;
    localparam op_t OP_BGTZ    = 6'b000111;
    localparam op_t OP_ADDI    = 6'b001000;
    localparam op_t OP_ADDIU   = 6'b001001;
    localparam op_t OP_SLTI    = 6'b001010;
    localparam op_t OP_SLTIU   = 6'b001011;
    localparam op_t OP_ANDI    = 6'b001100;
    localparam op_t OP_ORI     = 6'b001101;
    localparam op_t OP_XORI    = 6'b001110;
    localparam op_t OP_LUI     = 6'b001111;

    localparam func_t F_SLL  = 6'b000000;
    localparam func_t F_SRL  = 6'b000010;
    localparam func_t F_SRA  = 6'b000011;
    localparam func_t F_SLLV = 6'b000100;
    localparam func_t F_SRLV = 6'b000110;
    localparam func_t F_SRAV = 6'b000111;
    localparam func_t F_JR   = 6'b001000;
    localparam func_t F_JALR = 6'b001001;
    localparam func_t F_ADD  = 6'b100000;
    localparam func_t F_ADDU = 6'b100001;
    localparam func_t F_SUB  = 6'b100010;
    localparam func_t F_SUBU = 6'b100011;
    localparam func_t F_AND  = 6'b100100;
    localparam func_t F_OR   = 6'b100101;
    localparam func_t F_XOR  = 6'b100110;
    localparam func_t F_NOR  = 6'b100111;
    localparam func_t F_SLT  = 6'b101010;
    localparam func_t F_SLTU = 6'b101011;

    localparam creg_addr_t B_BLTZ   = 5'b00000;
    localparam creg_addr_t B_BGEZ   = 5'b00001;
    localparam creg_addr_t B_BLTZAL = 5'b10000;
    localparam creg_addr_t B_BGEZAL = 5'b10001;

    localparam creg_addr_t LINK_REG = 5'd31; // return address register

    // **********************************************************************
    // control encodings and records
    // **********************************************************************
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASSA
    } alu_func_t;

    typedef enum logic [1:0] {REGB, IMM, SHAMT} alu_src_t;

    typedef enum logic [2:0] {
        T_NONE, T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ
    } branch_type_t;

    typedef struct packed {
        alu_func_t    alu_func;
        alu_src_t     alu_src;
        logic         zero_ext;     // logic immediates
        logic         reg_write;
        branch_type_t branch_type;
        logic         jump;
        logic         jr;           // target from rs
        logic         link;         // write pc + 4
        logic         exception_ri;
    } control_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        creg_addr_t dest;
        word_t      data;
        logic       reg_write;
        logic       exception_ri;
    } retire_t;

endpackage

// File: design/main_decode.sv
`timescale 1ns/1ps

module main_decode (
    input  mips_pkg::word_t      instr,
    output mips_pkg::control_t   ctl,
    output mips_pkg::creg_addr_t src_a,
    output mips_pkg::creg_addr_t src_b,
    output mips_pkg::creg_addr_t dest
);
    import mips_pkg::*;

    op_t        op;
    func_t      func;
    creg_addr_t rs, rt, rd;

    assign op   = instr[31:26];
    assign rs   = instr[25:21];
    assign rt   = instr[20:16];
    assign rd   = instr[15:11];
    assign func = instr[5:0];

    always_comb begin
        ctl   = '0;
        src_a = '0;
        src_b = '0;
        dest  = '0;
        case (op)
            // **************************************************************
            // r-type, selected by function field
            // **************************************************************
            OP_SPECIAL: begin
                ctl.reg_write = 1'b1;
                ctl.alu_src   = REGB;
                src_a         = rs;
                src_b         = rt;
                dest          = rd;
                case (func)
                    F_ADD, F_ADDU: ctl.alu_func = ALU_ADD; // no overflow trap
                    F_SUB, F_SUBU: ctl.alu_func = ALU_SUB;
                    F_SLT:  ctl.alu_func = ALU_SLT;
                    F_SLTU: ctl.alu_func = ALU_SLTU;
                    F_AND:  ctl.alu_func = ALU_AND;
                    F_OR:   ctl.alu_func = ALU_OR;
                    F_XOR:  ctl.alu_func = ALU_XOR;
                    F_NOR:  ctl.alu_func = ALU_NOR;
                    F_SLLV: ctl.alu_func = ALU_SLL;
                    F_SRLV: ctl.alu_func = ALU_SRL;
                    F_SRAV: ctl.alu_func = ALU_SRA;
                    F_SLL, F_SRL, F_SRA: begin
                        ctl.alu_src = SHAMT;
                        src_a       = '0;
                        if (func == F_SLL)
                            ctl.alu_func = ALU_SLL;
                        else if (func == F_SRL)
                            ctl.alu_func = ALU_SRL;
                        else
                            ctl.alu_func = ALU_SRA;
                    end
                    F_JR, F_JALR: begin
                        ctl.alu_func  = ALU_PASSA;
                        ctl.jump      = 1'b1;
                        ctl.jr        = 1'b1;
                        ctl.link      = (func == F_JALR);
                        ctl.reg_write = (func == F_JALR);
                        src_b         = '0;
                        dest          = (func == F_JALR) ? LINK_REG : '0;
                    end
                    default: ctl.exception_ri = 1'b1;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctl.reg_write = 1'b1;
                ctl.alu_src   = IMM;
                src_a         = (op == OP_LUI) ? '0 : rs;
                dest          = rt;
                ctl.zero_ext  = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
                case (op)
                    OP_SLTI:  ctl.alu_func = ALU_SLT;
                    OP_SLTIU: ctl.alu_func = ALU_SLTU;
                    OP_ANDI:  ctl.alu_func = ALU_AND;
                    OP_ORI:   ctl.alu_func = ALU_OR;
                    OP_XORI:  ctl.alu_func = ALU_XOR;
                    OP_LUI:   ctl.alu_func = ALU_LUI;
                    default:  ctl.alu_func = ALU_ADD;
                endcase
            end
            // **************************************************************
            // branches and jumps
            // **************************************************************
            OP_BEQ, OP_BNE: begin
                ctl.branch_type = (op == OP_BEQ) ? T_BEQ : T_BNE;
                src_a           = rs;
                src_b           = rt;
            end
            OP_BGTZ: begin
                ctl.branch_type = T_BGTZ;
                src_a           = rs;
            end
            OP_BLEZ: begin
                ctl.branch_type = T_BLEZ;
                src_a           = rs;
            end
            OP_REGIMM: begin
                src_a = rs;
                case (rt)
                    B_BGEZ, B_BGEZAL: ctl.branch_type = T_BGEZ;
                    B_BLTZ, B_BLTZAL: ctl.branch_type = T_BLTZ;
                    default:          ctl.exception_ri = 1'b1;
                endcase
                if (rt == B_BGEZAL || rt == B_BLTZAL) begin
                    ctl.link      = 1'b1; // links whether taken or not
                    ctl.reg_write = 1'b1;
                    dest          = LINK_REG;
                end
            end
            OP_J, OP_JAL: begin
                ctl.jump      = 1'b1;
                ctl.link      = (op == OP_JAL);
                ctl.reg_write = (op == OP_JAL);
                dest          = (op == OP_JAL) ? LINK_REG : '0;
            end
            default: ctl.exception_ri = 1'b1;
        endcase

        // reserved codes leave nothing behind
        if (ctl.exception_ri) begin
            ctl           = '0;
            ctl.alu_func  = ALU_PASSA;
            ctl.exception_ri = 1'b1;
            src_a         = '0;
            src_b         = '0;
            dest          = '0;
        end
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,
    input  mips_pkg::creg_addr_t waddr,
    input  mips_pkg::word_t      wdata,
    input  mips_pkg::creg_addr_t raddr_a,
    input  mips_pkg::creg_addr_t raddr_b,
    output mips_pkg::word_t      rdata_a,
    output mips_pkg::word_t      rdata_b
);
    import mips_pkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // r0 is hardwired
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  mips_pkg::control_t ctl,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    input  logic [15:0]        imm,
    input  mips_pkg::shamt_t   shamt,
    output mips_pkg::word_t    result
);
    import mips_pkg::*;

    word_t  imm_ext;
    word_t  op_b;
    shamt_t sh_amt;

    assign imm_ext = ctl.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    always_comb begin
        case (ctl.alu_src)
            IMM:     op_b = imm_ext;
            SHAMT:   op_b = {27'b0, shamt};
            default: op_b = rt_data;
        endcase
    end

    // variable shifts take the amount from rs
    assign sh_amt = (ctl.alu_src == SHAMT) ? op_b[4:0] : rs_data[4:0];

    always_comb begin
        case (ctl.alu_func)
            ALU_ADD:   result = rs_data + op_b;
            ALU_SUB:   result = rs_data - op_b;
            ALU_SLT:   result = {31'b0, $signed(rs_data) < $signed(op_b)};
            ALU_SLTU:  result = {31'b0, rs_data < op_b};
            ALU_AND:   result = rs_data & op_b;
            ALU_OR:    result = rs_data | op_b;
            ALU_XOR:   result = rs_data ^ op_b;
            ALU_NOR:   result = ~(rs_data | op_b);
            ALU_SLL:   result = rt_data << sh_amt;
            ALU_SRL:   result = rt_data >> sh_amt;
            ALU_SRA:   result = $signed(rt_data) >>> sh_amt; // sign fill
            ALU_LUI:   result = {op_b[15:0], 16'h0000};
            ALU_PASSA: result = rs_data;
            default:   result = '0;
        endcase
    end

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  mips_pkg::control_t ctl,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    input  logic [15:0]        imm,
    input  logic [25:0]        index,
    output mips_pkg::word_t    pc,
    output mips_pkg::word_t    link_addr
);
    import mips_pkg::*;

    word_t pc_plus4, branch_target, jump_target, pc_next;
    logic  taken;

    assign pc_plus4      = pc + 32'd4;
    assign link_addr     = pc_plus4; // no delay slot
    assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], index, 2'b00};

    always_comb begin
        case (ctl.branch_type)
            T_BEQ:   taken = (rs_data == rt_data);
            T_BNE:   taken = (rs_data != rt_data);
            T_BGEZ:  taken = !rs_data[31];
            T_BLTZ:  taken = rs_data[31];
            T_BGTZ:  taken = $signed(rs_data) > 0;
            T_BLEZ:  taken = $signed(rs_data) <= 0;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctl.jr)
            pc_next = rs_data;
        else if (ctl.jump)
            pc_next = jump_target;
        else if (taken)
            pc_next = branch_target;
        else
            pc_next = pc_plus4; // reserved lands here too
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (instr_valid)
            pc <= pc_next;
    end

endmodule

// File: design/exec_core.sv
`timescale 1ns/1ps

module exec_core #(
    parameter mips_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  mips_pkg::word_t   instr,
    output mips_pkg::word_t   pc,
    output mips_pkg::retire_t retire
);
    import mips_pkg::*;

    control_t   ctl;
    creg_addr_t src_a, src_b, dest;
    word_t      rs_data, rt_data;
    word_t      alu_result, link_addr, wb_data;
    logic       wr_en;

    main_decode i_main_decode (
        .instr (instr),
        .ctl   (ctl),
        .src_a (src_a),
        .src_b (src_b),
        .dest  (dest)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (wr_en),
        .waddr   (dest),
        .wdata   (wb_data),
        .raddr_a (src_a),
        .raddr_b (src_b),
        .rdata_a (rs_data),
        .rdata_b (rt_data)
    );

    alu i_alu (
        .ctl     (ctl),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .imm     (instr[15:0]),
        .shamt   (instr[10:6]),
        .result  (alu_result)
    );

    branch_unit #(
        .RESET_PC (RESET_PC)
    ) i_branch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .ctl         (ctl),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .imm         (instr[15:0]),
        .index       (instr[25:0]),
        .pc          (pc),
        .link_addr   (link_addr)
    );

    assign wb_data = ctl.link ? link_addr : alu_result;
    assign wr_en   = instr_valid && ctl.reg_write && !ctl.exception_ri;

    // one retire record per strobed instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire <= '0;
        end else begin
            retire.valid <= instr_valid;
            if (instr_valid) begin
                retire.pc           <= pc;
                retire.dest         <= dest;
                retire.data         <= wb_data;
                retire.reg_write    <= wr_en;
                retire.exception_ri <= ctl.exception_ri;
            end
        end
    end

endmodule

// File: verification/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;
    import mips_pkg::*;

    localparam word_t START_PC   = 32'h0000_1000;
    localparam int    MAX_CYCLES = 400; // about 80 instructions at two cycles each plus margin

    logic    clk = 1'b0;
    logic    rst_n;
    logic    instr_valid;
    word_t   instr;
    word_t   pc;
    retire_t retire;

    word_t  model_regs [0:31]; // reference register file
    word_t  model_pc;
    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     tests  = 0;
    int     cycles = 0;

    exec_core #(
        .RESET_PC (START_PC)
    ) i_exec_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .retire      (retire)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // **********************************************************************
    // instruction encoding
    // **********************************************************************
    function automatic word_t r_type(func_t f, creg_addr_t rs, creg_addr_t rt,
                                     creg_addr_t rd, shamt_t sh);
        return {OP_SPECIAL, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t i_type(op_t op, creg_addr_t rs, creg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(op_t op, logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t j_target(word_t cur, logic [25:0] idx);
        word_t p4;
        p4 = cur + 32'd4;
        return {p4[31:28], idx, 2'b00}; // region of pc + 4
    endfunction

    // **********************************************************************
    // drive and check
    // **********************************************************************
    task automatic check(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic step(input word_t ins, input logic exp_we, input creg_addr_t exp_dest,
                        input word_t exp_data, input logic exp_ri, input word_t exp_next);
        @(negedge clk);
        instr       = ins;
        instr_valid = 1'b1;
        @(negedge clk); // retire record was loaded at the rising edge in between
        instr_valid = 1'b0;
        check("retire.valid", 32'(retire.valid), 32'd1);
        check("retire.pc", retire.pc, model_pc);
        check("retire.reg_write", 32'(retire.reg_write), 32'(exp_we));
        check("retire.exception_ri", 32'(retire.exception_ri), 32'(exp_ri));
        if (exp_we) begin
            check("retire.dest", 32'(retire.dest), 32'(exp_dest));
            check("retire.data", retire.data, exp_data);
        end
        check("pc", pc, exp_next);
        if (exp_we && exp_dest != 5'd0)
            model_regs[exp_dest] = exp_data;
        model_pc = exp_next;
    endtask

    task automatic write_op(input word_t ins, input creg_addr_t rd, input word_t value);
        step(ins, 1'b1, rd, value, 1'b0, model_pc + 32'd4);
    endtask

    task automatic load_reg(input creg_addr_t r, input word_t value);
        write_op(i_type(OP_LUI, 5'd0, r, value[31:16]), r, {value[31:16], 16'h0000});
        write_op(i_type(OP_ORI, r, r, value[15:0]), r, model_regs[r] | {16'h0000, value[15:0]});
    endtask

    task automatic read_back(input creg_addr_t r);
        write_op(r_type(F_OR, r, 5'd0, 5'd26, 5'd0), 5'd26, model_regs[r]); // r26 is scratch
    endtask

    task automatic branch(input word_t ins, input logic taken, input logic link);
        word_t next;
        next = model_pc + 32'd4;
        if (taken)
            next = next + (sext16(ins[15:0]) << 2);
        step(ins, link, LINK_REG, model_pc + 32'd4, 1'b0, next);
    endtask

    task automatic reserved(input word_t ins);
        step(ins, 1'b0, 5'd0, 32'd0, 1'b1, model_pc + 32'd4);
    endtask

    task automatic report(input string name, input int start);
        tests++;
        $display("%-10s %s (%0d errors)", name,
                 (errors == start) ? "passed" : "failed", errors - start);
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************
    task automatic test_immediate();
        int          start;
        logic [15:0] imm;
        start = errors;
        imm   = 16'($random(seed)) | 16'h8000; // top bit set so zero extension shows
        load_reg(5'd1, $random(seed));
        write_op(i_type(OP_ANDI, 5'd1, 5'd2, imm), 5'd2, model_regs[1] & {16'h0000, imm});
        write_op(i_type(OP_ORI, 5'd1, 5'd3, imm), 5'd3, model_regs[1] | {16'h0000, imm});
        write_op(i_type(OP_XORI, 5'd1, 5'd4, imm), 5'd4, model_regs[1] ^ {16'h0000, imm});
        write_op(i_type(OP_ADDIU, 5'd1, 5'd5, imm), 5'd5, model_regs[1] + sext16(imm));
        write_op(i_type(OP_LUI, 5'd0, 5'd6, imm), 5'd6, {imm, 16'h0000});
        // r0 accepts the write and still reads zero
        write_op(i_type(OP_ADDIU, 5'd1, 5'd0, imm), 5'd0, model_regs[1] + sext16(imm));
        read_back(5'd0);
        report("immediate", start);
    endtask

    task automatic test_register();
        int    start;
        word_t a;
        word_t b;
        start = errors;
        load_reg(5'd8, $random(seed));
        load_reg(5'd9, $random(seed));
        a = model_regs[8];
        b = model_regs[9];
        write_op(r_type(F_ADD, 5'd8, 5'd9, 5'd10, 5'd0), 5'd10, a + b);
        write_op(r_type(F_SUB, 5'd8, 5'd9, 5'd10, 5'd0), 5'd10, a - b);
        write_op(r_type(F_AND, 5'd8, 5'd9, 5'd10, 5'd0), 5'd10, a & b);
        write_op(r_type(F_OR, 5'd8, 5'd9, 5'd10, 5'd0), 5'd10, a | b);
        write_op(r_type(F_XOR, 5'd8, 5'd9, 5'd10, 5'd0), 5'd10, a ^ b);
        write_op(r_type(F_NOR, 5'd8, 5'd9, 5'd10, 5'd0), 5'd10, ~(a | b));
        // negative against positive so signed and unsigned orders disagree
        load_reg(5'd11, $random(seed) | 32'h8000_0000);
        load_reg(5'd12, $random(seed) & 32'h0000_ffff);
        write_op(r_type(F_SLT, 5'd11, 5'd12, 5'd13, 5'd0), 5'd13, 32'd1);
        write_op(r_type(F_SLTU, 5'd11, 5'd12, 5'd13, 5'd0), 5'd13, 32'd0);
        write_op(r_type(F_SLT, 5'd12, 5'd11, 5'd13, 5'd0), 5'd13, 32'd0);
        write_op(r_type(F_SLTU, 5'd12, 5'd11, 5'd13, 5'd0), 5'd13, 32'd1);
        report("register", start);
    endtask

    task automatic test_shift();
        int     start;
        shamt_t sh;
        word_t  v;
        start = errors;
        sh    = 5'($random(seed)) | 5'd1;
        load_reg(5'd14, $random(seed) | 32'h8000_0000); // negative so SRA fills with ones
        load_reg(5'd15, $random(seed) | 32'd1); // amount never zero
        v = model_regs[14];
        write_op(r_type(F_SLL, 5'd0, 5'd14, 5'd16, sh), 5'd16, v << sh);
        write_op(r_type(F_SRL, 5'd0, 5'd14, 5'd16, sh), 5'd16, v >> sh);
        write_op(r_type(F_SRA, 5'd0, 5'd14, 5'd16, sh), 5'd16, $signed(v) >>> sh);
        write_op(r_type(F_SLLV, 5'd15, 5'd14, 5'd16, 5'd0), 5'd16, v << model_regs[15][4:0]);
        write_op(r_type(F_SRLV, 5'd15, 5'd14, 5'd16, 5'd0), 5'd16, v >> model_regs[15][4:0]);
        write_op(r_type(F_SRAV, 5'd15, 5'd14, 5'd16, 5'd0), 5'd16,
                 $signed(v) >>> model_regs[15][4:0]);
        report("shift", start);
    endtask

    task automatic test_branch();
        int start;
        start = errors;
        load_reg(5'd20, 32'd5);
        load_reg(5'd21, 32'd5);
        load_reg(5'd22, 32'hffff_fffd);
        branch(i_type(OP_BEQ, 5'd20, 5'd21, 16'h0010), 1'b1, 1'b0);
        branch(i_type(OP_BEQ, 5'd20, 5'd22, 16'h0010), 1'b0, 1'b0);
        branch(i_type(OP_BNE, 5'd20, 5'd22, 16'hfff8), 1'b1, 1'b0);
        branch(i_type(OP_BNE, 5'd20, 5'd21, 16'hfff8), 1'b0, 1'b0);
        branch(i_type(OP_REGIMM, 5'd20, B_BGEZ, 16'h0020), 1'b1, 1'b0);
        branch(i_type(OP_REGIMM, 5'd22, B_BGEZ, 16'h0020), 1'b0, 1'b0);
        branch(i_type(OP_REGIMM, 5'd22, B_BLTZ, 16'hfff0), 1'b1, 1'b0);
        branch(i_type(OP_REGIMM, 5'd20, B_BLTZ, 16'hfff0), 1'b0, 1'b0);
        branch(i_type(OP_BGTZ, 5'd20, 5'd0, 16'h0004), 1'b1, 1'b0);
        branch(i_type(OP_BGTZ, 5'd0, 5'd0, 16'h0004), 1'b0, 1'b0);
        branch(i_type(OP_BLEZ, 5'd22, 5'd0, 16'h0008), 1'b1, 1'b0);
        branch(i_type(OP_BLEZ, 5'd0, 5'd0, 16'h0008), 1'b1, 1'b0);
        branch(i_type(OP_BLEZ, 5'd20, 5'd0, 16'h0008), 1'b0, 1'b0);
        branch(i_type(OP_REGIMM, 5'd20, B_BGEZAL, 16'h0040), 1'b1, 1'b1);
        branch(i_type(OP_REGIMM, 5'd20, B_BLTZAL, 16'h0040), 1'b0, 1'b1); // links anyway
        read_back(LINK_REG);
        report("branch", start);
    endtask

    task automatic test_jump();
        int          start;
        logic [25:0] idx;
        start = errors;
        idx   = 26'($random(seed));
        step(j_type(OP_J, idx), 1'b0, 5'd0, 32'd0, 1'b0, j_target(model_pc, idx));
        idx = 26'($random(seed));
        step(j_type(OP_JAL, idx), 1'b1, LINK_REG, model_pc + 32'd4, 1'b0,
             j_target(model_pc, idx));
        load_reg(5'd24, $random(seed) & 32'h0fff_fffc);
        step(r_type(F_JR, 5'd24, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0, 1'b0, model_regs[24]);
        load_reg(5'd25, $random(seed) & 32'h0fff_fffc);
        step(r_type(F_JALR, 5'd25, 5'd0, LINK_REG, 5'd0), 1'b1, LINK_REG, model_pc + 32'd4,
             1'b0, model_regs[25]);
        read_back(LINK_REG);
        report("jump", start);
    endtask

    task automatic test_reserved();
        int start;
        start = errors;
        load_reg(5'd2, $random(seed));
        reserved(i_type(6'b100011, 5'd1, 5'd2, 16'h0004));       // lw
        reserved(r_type(6'b011000, 5'd1, 5'd2, 5'd3, 5'd0));     // mult
        reserved(i_type(OP_REGIMM, 5'd1, 5'b10011, 16'h0004));   // unknown regimm code
        read_back(5'd2);
        read_back(5'd3);
        read_back(LINK_REG);
        report("reserved", start);
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'h7295;
        model_pc    = START_PC;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("pc", pc, START_PC);
        check("retire.valid", 32'(retire.valid), 32'd0);
        test_immediate();
        test_register();
        test_shift();
        test_branch();
        test_jump();
        test_reserved();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sources.f
design/mips_pkg.sv
design/main_decode.sv
design/reg_file.sv
design/alu.sv
design/branch_unit.sv
design/exec_core.sv
verification/tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_exec_core -o tb_exec_core

out=$(./obj_dir/tb_exec_core)
echo "$out"
echo "$out" | grep -qx "TEST OK"
